// File: common/ram_test_pkg.sv
package ram_test_pkg;

	// bus widths
	localparam int freq_w = 9;
	localparam int addr_w = 10;
	localparam int byte_w = 8;
	localparam int seg_w = 7;

	// phase lengths in CLOCK_50 cycles
	localparam int write_cycles = 3000;
	localparam int settle_cycles = 10000;
	localparam int run_cycles = 420000;
	localparam int uart_gap = 10000;

	// counter widths sized from the longest phase and the byte gap
	localparam int phase_w = $clog2(run_cycles + 1);
	localparam int gap_w = $clog2(uart_gap + 1);

	// report codes, both use the low view with the flag bit set
	localparam logic [byte_w-1:0] marker_freq = 8'h7F;
	localparam logic [byte_w-1:0] marker_err = 8'h40;

	typedef logic [freq_w-1:0] freq_t;
	typedef logic [addr_w-1:0] addr_t;

	// status from the RAM controller, two independent checker ports
	typedef struct packed {
		logic err_a;
		addr_t addr_a;
		logic err_b;
		addr_t addr_b;
	} mem_status_t;

	typedef struct packed {
		logic align;
		logic write_mem;
	} mem_ctrl_t;

	typedef struct packed {
		logic pll_reset;
		logic next_frequency;
	} pll_ctrl_t;

	// one report byte, read either as markers/low address or high address
	typedef union packed {
		struct packed {
			logic zero;
			logic flag;
			logic [5:0] payload;
		} lo;
		struct packed {
			logic [3:0] zero;
			logic [3:0] payload;
		} hi;
	} report_byte_u;

	typedef struct packed {
		logic [seg_w-1:0] hex0;
		logic [seg_w-1:0] hex1;
		logic [seg_w-1:0] hex2;
		logic [seg_w-1:0] hex3;
		logic [seg_w-1:0] hex4;
		logic [seg_w-1:0] hex5;
	} hex_bank_t;

	// address bits 5..0, flag clear so it can't be taken for a marker
	function automatic report_byte_u addr_lo_byte(addr_t addr);
		report_byte_u b;
		b = '0;
		b.lo.payload = addr[5:0];
		return b;
	endfunction

	function automatic report_byte_u addr_hi_byte(addr_t addr);
		report_byte_u b;
		b = '0;
		b.hi.payload = addr[9:6];
		return b;
	endfunction

endpackage

// File: src/hex_display.sv
`timescale 1ns/1ps

module hex_display (
	input logic [3:0] number,
	output logic [6:0] hex
);

	// bit 0 is segment a, a low bit lights the segment
	always_comb begin
		case (number)
			4'h0: hex = 7'h40;
			4'h1: hex = 7'h79;
			4'h2: hex = 7'h24;
			4'h3: hex = 7'h30;
			4'h4: hex = 7'h19;
			4'h5: hex = 7'h12;
			4'h6: hex = 7'h02;
			4'h7: hex = 7'h78;
			4'h8: hex = 7'h00;
			4'h9: hex = 7'h10;
			4'ha: hex = 7'h08;
			4'hb: hex = 7'h03;
			4'hc: hex = 7'h46;
			4'hd: hex = 7'h21;
			4'he: hex = 7'h06;
			4'hf: hex = 7'h0E;
			default: hex = 7'h7F;
		endcase
	end

endmodule

// File: sweep/sweep_sequencer.sv
`timescale 1ns/1ps

module sweep_sequencer (
	input logic CLOCK_50,
	input logic rst,
	input logic freq_ready,
	input logic pause,
	input logic freq_reported,
	output ram_test_pkg::pll_ctrl_t pll_ctrl,
	output ram_test_pkg::mem_ctrl_t mem_ctrl,
	output logic testing,
	output logic freq_step
);
	import ram_test_pkg::*;

	typedef enum logic [3:0] {
		s_pll_reset,
		s_lock,
		s_write,
		s_align,
		s_settle,
		s_test,
		s_next,
		s_wait_lock,
		s_report
	} state_t;

	state_t state;
	state_t next_state;
	logic [phase_w-1:0] phase_cnt;
	logic [phase_w-1:0] phase_limit;
	logic phase_done;

	// last count of the timed phase we are in
	always_comb begin
		case (state)
			s_write: phase_limit = phase_w'(write_cycles - 1);
			s_settle: phase_limit = phase_w'(settle_cycles - 1);
			default: phase_limit = phase_w'(run_cycles - 1);
		endcase
	end

	// a paused cycle never ends a phase
	assign phase_done = (phase_cnt == phase_limit) && !pause;

	always_comb begin
		next_state = state;
		case (state)
			s_pll_reset: next_state = s_lock;
			s_lock: if (freq_ready) next_state = s_write;
			s_write: if (phase_done) next_state = s_align;
			s_align: next_state = s_settle;
			s_settle: if (phase_done) next_state = s_test;
			s_test: if (phase_done) next_state = s_next;
			s_next: next_state = s_wait_lock;
			s_wait_lock: if (freq_ready) next_state = s_report;
			// marker must be out before the next frequency is tested
			s_report: if (freq_reported) next_state = s_align;
			default: next_state = s_pll_reset;
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst)
			state <= s_pll_reset;
		else
			state <= next_state;
	end

	// restarts on every state change, holds while an error frame goes out
	always_ff @(posedge CLOCK_50) begin
		if (rst || next_state != state)
			phase_cnt <= '0;
		else if (!pause)
			phase_cnt <= phase_cnt + 1'b1;
	end

	// external controls are registered, one cycle behind the state
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			pll_ctrl <= '0;
			mem_ctrl <= '0;
		end else begin
			pll_ctrl.pll_reset <= (state == s_pll_reset);
			pll_ctrl.next_frequency <= (state == s_next);
			mem_ctrl.write_mem <= (state == s_write);
			mem_ctrl.align <= (state == s_align);
		end
	end

	// handshake levels follow the state directly
	assign testing = (state == s_test);
	assign freq_step = (state == s_report);

endmodule

// File: report/error_capture.sv
`timescale 1ns/1ps

module error_capture (
	input logic CLOCK_50,
	input logic rst,
	input logic testing,
	input logic clear_errors,
	input ram_test_pkg::mem_status_t mem_status,
	input ram_test_pkg::freq_t frequency,
	output ram_test_pkg::mem_status_t captured,
	output logic any_error,
	output ram_test_pkg::freq_t first_fail
);

	logic capture_a;
	logic capture_b;
	logic fail_seen;
	logic flush;

	assign flush = rst || clear_errors || !testing;

	// only the first error of each port sticks until the next clear
	assign capture_a = !flush && mem_status.err_a && !captured.err_a;
	assign capture_b = !flush && mem_status.err_b && !captured.err_b;

	always_ff @(posedge CLOCK_50) begin
		if (capture_a)
			captured.addr_a <= mem_status.addr_a;
		if (capture_b)
			captured.addr_b <= mem_status.addr_b;
		if (flush) begin
			captured.err_a <= 1'b0;
			captured.err_b <= 1'b0;
			any_error <= 1'b0;
		end else begin
			if (capture_a)
				captured.err_a <= 1'b1;
			if (capture_b)
				captured.err_b <= 1'b1;
			any_error <= captured.err_a || captured.err_b;
		end
	end

	// first failing frequency since reset, kept for the display
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			first_fail <= '0;
			fail_seen <= 1'b0;
		end else if (testing && (mem_status.err_a || mem_status.err_b) && !fail_seen) begin
			first_fail <= frequency;
			fail_seen <= 1'b1;
		end
	end

endmodule

// File: report/error_reporter.sv
`timescale 1ns/1ps

module error_reporter (
	input logic CLOCK_50,
	input logic rst,
	input logic testing,
	input logic freq_step,
	input logic any_error,
	input ram_test_pkg::mem_status_t captured,
	output logic [ram_test_pkg::byte_w-1:0] uart_data,
	output logic uart_valid,
	output logic pause,
	output logic freq_reported,
	output logic clear_errors
);
	import ram_test_pkg::*;

	typedef enum logic {
		r_idle,
		r_gap
	} state_t;

	state_t state;
	logic err_frame;
	logic [2:0] slot;
	logic [2:0] next_slot;
	logic [gap_w-1:0] gap_cnt;
	logic gap_done;
	report_byte_u slot_byte;
	logic slot_send;

	assign gap_done = (state == r_gap) && (gap_cnt == gap_w'(uart_gap - 1));
	assign next_slot = slot + 3'd1;

	// sequencer freezes its window for the whole error frame
	assign pause = (state == r_gap) && err_frame;
	assign freq_reported = gap_done && !err_frame;

	// slot 4 is the last byte of an error frame
	assign clear_errors = gap_done && err_frame && (slot == 3'd4);

	// frame layout after marker_err: a low, a high, b low, b high
	always_comb begin
		slot_byte = '0;
		slot_send = 1'b0;
		case (next_slot)
			3'd1: begin
				slot_byte = addr_lo_byte(captured.addr_a);
				slot_send = captured.err_a;
			end
			3'd2: begin
				slot_byte = addr_hi_byte(captured.addr_a);
				slot_send = captured.err_a;
			end
			3'd3: begin
				slot_byte = addr_lo_byte(captured.addr_b);
				slot_send = captured.err_b;
			end
			3'd4: begin
				slot_byte = addr_hi_byte(captured.addr_b);
				slot_send = captured.err_b;
			end
			default: begin
				slot_byte = '0;
				slot_send = 1'b0;
			end
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= r_idle;
			err_frame <= 1'b0;
			slot <= '0;
			gap_cnt <= '0;
			uart_valid <= 1'b0;
		end else begin
			uart_valid <= 1'b0;
			gap_cnt <= gap_cnt + 1'b1;
			case (state)
				r_idle: begin
					gap_cnt <= '0;
					slot <= '0;
					if (freq_step) begin
						uart_data <= marker_freq;
						uart_valid <= 1'b1;
						err_frame <= 1'b0;
						state <= r_gap;
					end else if (any_error && testing) begin
						uart_data <= marker_err;
						uart_valid <= 1'b1;
						err_frame <= 1'b1;
						state <= r_gap;
					end
				end
				r_gap: begin
					if (gap_done) begin
						gap_cnt <= '0;
						if (!err_frame || slot == 3'd4) begin
							state <= r_idle;
						end else begin
							// skipped bytes still sit out their gap
							slot <= next_slot;
							uart_data <= slot_byte;
							uart_valid <= slot_send;
						end
					end
				end
				default: state <= r_idle;
			endcase
		end
	end

endmodule

// File: src/ram_margin_tester.sv
`timescale 1ns/1ps

module ram_margin_tester (
	input logic CLOCK_50,
	input logic rst,
	input ram_test_pkg::freq_t frequency,
	input logic freq_ready,
	input ram_test_pkg::mem_status_t mem_status,
	output ram_test_pkg::pll_ctrl_t pll_ctrl,
	output ram_test_pkg::mem_ctrl_t mem_ctrl,
	output logic [ram_test_pkg::byte_w-1:0] uart_data,
	output logic uart_valid,
	output wire ram_test_pkg::hex_bank_t hex
);
	import ram_test_pkg::*;

	logic testing;
	logic freq_step;
	logic freq_reported;
	logic pause;
	logic clear_errors;
	logic any_error;
	mem_status_t captured;
	freq_t first_fail;

	sweep_sequencer u_seq (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.freq_ready(freq_ready),
		.pause(pause),
		.freq_reported(freq_reported),
		.pll_ctrl(pll_ctrl),
		.mem_ctrl(mem_ctrl),
		.testing(testing),
		.freq_step(freq_step)
	);

	error_capture u_capture (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.testing(testing),
		.clear_errors(clear_errors),
		.mem_status(mem_status),
		.frequency(frequency),
		.captured(captured),
		.any_error(any_error),
		.first_fail(first_fail)
	);

	error_reporter u_reporter (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.testing(testing),
		.freq_step(freq_step),
		.any_error(any_error),
		.captured(captured),
		.uart_data(uart_data),
		.uart_valid(uart_valid),
		.pause(pause),
		.freq_reported(freq_reported),
		.clear_errors(clear_errors)
	);

	// current frequency, top digit carries bit 8 only
	hex_display u_hex0 (.number(frequency[3:0]), .hex(hex.hex0));
	hex_display u_hex1 (.number(frequency[7:4]), .hex(hex.hex1));
	hex_display u_hex2 (.number({3'b000, frequency[8]}), .hex(hex.hex2));

	// first failing frequency
	hex_display u_hex3 (.number(first_fail[3:0]), .hex(hex.hex3));
	hex_display u_hex4 (.number(first_fail[7:4]), .hex(hex.hex4));
	hex_display u_hex5 (.number({3'b000, first_fail[8]}), .hex(hex.hex5));

endmodule

// File: test/tb_ram_margin.sv
`timescale 1ns/1ps

module tb_ram_margin;
	import ram_test_pkg::*;

	localparam freq_t start_freq = 9'h0FF;
	localparam longint step_cycles = longint'(write_cycles + settle_cycles + run_cycles
		+ 5 * uart_gap);
	localparam longint watchdog_ns = 3 * step_cycles * 40 * 2;

	logic CLOCK_50 = 1'b0;
	logic rst;
	freq_t frequency = '0;
	logic freq_ready = 1'b0;
	mem_status_t mem_status;
	pll_ctrl_t pll_ctrl;
	mem_ctrl_t mem_ctrl;
	logic [byte_w-1:0] uart_data;
	logic uart_valid;
	hex_bank_t hex;

	logic [byte_w-1:0] expected_q[$];
	logic [byte_w-1:0] exp_byte;
	freq_t expected_fail = '0;
	logic fail_seen = 1'b0;
	logic ready_seen = 1'b0;
	int errors = 0;
	int hex_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int bytes_seen = 0;
	int pll_pulses = 0;
	int cycle = 0;
	int last_valid = 0;
	int lock_cnt = 0;
	int write_len;
	int mark;

	ram_margin_tester dut (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.frequency(frequency),
		.freq_ready(freq_ready),
		.mem_status(mem_status),
		.pll_ctrl(pll_ctrl),
		.mem_ctrl(mem_ctrl),
		.uart_data(uart_data),
		.uart_valid(uart_valid),
		.hex(hex)
	);

	always #20 CLOCK_50 = ~CLOCK_50;

	// active low with bit 0 as segment a
	function automatic logic [6:0] seg_of(input logic [3:0] n);
		logic [6:0] s;
		case (n)
			4'h0: s = 7'b1000000;
			4'h1: s = 7'b1111001;
			4'h2: s = 7'b0100100;
			4'h3: s = 7'b0110000;
			4'h4: s = 7'b0011001;
			4'h5: s = 7'b0010010;
			4'h6: s = 7'b0000010;
			4'h7: s = 7'b1111000;
			4'h8: s = 7'b0000000;
			4'h9: s = 7'b0010000;
			4'ha: s = 7'b0001000;
			4'hb: s = 7'b0000011;
			4'hc: s = 7'b1000110;
			4'hd: s = 7'b0100001;
			4'he: s = 7'b0000110;
			default: s = 7'b0001110;
		endcase
		return s;
	endfunction

	function automatic hex_bank_t expected_hex(input freq_t f, input freq_t fail);
		hex_bank_t h;
		h.hex0 = seg_of(f[3:0]);
		h.hex1 = seg_of(f[7:4]);
		h.hex2 = seg_of({3'b000, f[8]});
		h.hex3 = seg_of(fail[3:0]);
		h.hex4 = seg_of(fail[7:4]);
		h.hex5 = seg_of({3'b000, fail[8]});
		return h;
	endfunction

	// bytes of one frequency step with the error frame ahead of the marker
	function automatic void add_expected(input logic err_a, input addr_t addr_a,
		input logic err_b, input addr_t addr_b);
		if (err_a || err_b) begin
			expected_q.push_back(marker_err);
			if (err_a) begin
				expected_q.push_back({2'b00, addr_a[5:0]});
				expected_q.push_back({4'h0, addr_a[9:6]});
			end
			if (err_b) begin
				expected_q.push_back({2'b00, addr_b[5:0]});
				expected_q.push_back({4'h0, addr_b[9:6]});
			end
		end
		expected_q.push_back(marker_freq);
	endfunction

	task automatic finish_test(input string name, input int failures);
		tests_run++;
		if (failures == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d errors", name, failures);
			tests_failed++;
		end
	endtask

	task automatic wait_align();
		while (!mem_ctrl.align)
			@(negedge CLOCK_50);
	endtask

	// one pulse inside the test window and an optional late repeat on port a
	task automatic run_error_step(input logic use_a, input logic use_b, input logic again_a);
		addr_t a;
		addr_t b;
		int offset;
		a = addr_t'($urandom_range(0, 1023));
		b = addr_t'($urandom_range(0, 1023));
		offset = int'($urandom_range(100, 100000));
		wait_align();
		repeat (settle_cycles + 2 + offset) @(negedge CLOCK_50);
		add_expected(use_a, a, use_b, b);
		if (!fail_seen) begin
			expected_fail <= frequency;
			fail_seen = 1'b1;
		end
		mem_status <= '{err_a: use_a, addr_a: a, err_b: use_b, addr_b: b};
		@(negedge CLOCK_50);
		mem_status <= '0;
		if (again_a) begin
			repeat (10) @(negedge CLOCK_50);
			mem_status.err_a <= 1'b1;
			mem_status.addr_a <= a ^ 10'h2AA;
			@(negedge CLOCK_50);
			mem_status <= '0;
		end
	endtask

	// synthesizer model relocks 5 to 20 cycles after each request
	always @(negedge CLOCK_50) begin
		if (rst) begin
			freq_ready <= 1'b0;
			lock_cnt <= 0;
		end else if (pll_ctrl.pll_reset || pll_ctrl.next_frequency) begin
			if (pll_ctrl.pll_reset)
				frequency <= start_freq;
			else
				frequency <= frequency + 1'b1;
			freq_ready <= 1'b0;
			lock_cnt <= int'($urandom_range(5, 20));
		end else if (lock_cnt > 1) begin
			lock_cnt <= lock_cnt - 1;
		end else if (lock_cnt == 1) begin
			lock_cnt <= 0;
			freq_ready <= 1'b1;
		end
	end

	// reset rules and display
	always @(negedge CLOCK_50) begin
		if (!rst) begin
			if (pll_ctrl.pll_reset)
				pll_pulses++;
			if (freq_ready)
				ready_seen = 1'b1;
			if (!ready_seen) begin
				assert (!uart_valid && !pll_ctrl.next_frequency && mem_ctrl == '0) else begin
					$display("control or report output active before the first lock");
					errors++;
				end
			end
			assert (hex == expected_hex(frequency, expected_fail)) else begin
				if (hex_errors < 10)
					$display("Mismatch hex: got %h expected %h", hex,
						expected_hex(frequency, expected_fail));
				hex_errors++;
			end
		end
	end

	// report byte comparison against the reference list
	always @(negedge CLOCK_50) begin
		if (!rst) begin
			cycle++;
			if (uart_valid) begin
				assert (bytes_seen == 0 || cycle - last_valid >= uart_gap) else begin
					$display("report bytes only %0d cycles apart", cycle - last_valid);
					errors++;
				end
				assert (expected_q.size() != 0) else begin
					$display("report byte %h arrived when none was expected", uart_data);
					errors++;
				end
				if (expected_q.size() != 0) begin
					exp_byte = expected_q.pop_front();
					assert (uart_data == exp_byte) else begin
						$display("Mismatch uart_data: got %h expected %h", uart_data, exp_byte);
						errors++;
					end
				end
				last_valid = cycle;
				bytes_seen++;
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("timeout, the sweep did not reach its last step in time");
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			errors + hex_errors);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(96));
		rst = 1'b1;
		mem_status = '0;
		repeat (4) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst <= 1'b0;

		mark = errors;
		while (!mem_ctrl.write_mem)
			@(negedge CLOCK_50);
		assert (ready_seen) else begin
			$display("write phase started before freq_ready");
			errors++;
		end
		write_len = 0;
		while (mem_ctrl.write_mem) begin
			write_len++;
			@(negedge CLOCK_50);
		end
		assert (write_len == write_cycles) else begin
			$display("Mismatch write_mem cycles: got %h expected %h", write_len, write_cycles);
			errors++;
		end
		assert (pll_pulses == 1) else begin
			$display("Mismatch pll_reset cycles: got %h expected %h", pll_pulses, 1);
			errors++;
		end
		finish_test("reset and write phase", errors - mark);

		mark = errors;
		run_error_step(1'b1, 1'b0, 1'b0);
		wait (bytes_seen >= 4);
		finish_test("port a error frame and marker", errors - mark);

		mark = errors;
		run_error_step(1'b1, 1'b1, 1'b1);
		wait (bytes_seen >= 10);
		finish_test("dual port error frame and marker", errors - mark);

		mark = errors;
		wait_align();
		add_expected(1'b0, '0, 1'b0, '0);
		@(negedge CLOCK_50);
		// the next align means freq_reported came back
		wait_align();
		assert (expected_q.size() == 0) else begin
			$display("%0d expected report bytes never arrived", expected_q.size());
			errors++;
		end
		finish_test("marker only step", errors - mark);
		finish_test("hex digits", hex_errors);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			errors + hex_errors);
		if (tests_failed == 0 && errors + hex_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: filelist.f
common/ram_test_pkg.sv
src/hex_display.sv
sweep/sweep_sequencer.sv
report/error_capture.sv
report/error_reporter.sv
src/ram_margin_tester.sv
test/tb_ram_margin.sv

// File: Makefile
SIM := obj_dir/Vtb_ram_margin

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

$(SIM): filelist.f $(shell cat filelist.f)
	verilator --binary -j 0 --assert --top-module tb_ram_margin -f filelist.f --Mdir obj_dir

clean:
	rm -rf obj_dir
